// File: hw/hazard_pkg.sv
`default_nettype none

package hazard_pkg;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    // I form, as used by OP-IMM and LOAD.
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } inst_i_t;

    // S form, as used by STORE; rs2 also sits here for R-type.
    typedef struct packed {
        logic [6:0]  imm_hi;
        logic [4:0]  rs2;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  imm_lo;
        logic [6:0]  opcode;
    } inst_s_t;

    typedef union packed {
        inst_i_t i;
        inst_s_t s;
    } inst_word_u;

    typedef struct packed {
        logic        uses_rs1;
        logic        uses_rs2;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic        writes_rd;
        logic [4:0]  rd;
        logic        is_load;
        logic        is_store;
        logic [11:0] offset;
    } cand_t;

    typedef struct packed {
        logic        valid;
        logic        writes_rd;
        logic [4:0]  rd;
        logic        is_load;
        logic        is_store;
        logic [4:0]  base;
        logic [11:0] offset;
    } slot_t;

    typedef struct packed {
        logic rs1_hit;
        logic rs2_hit;
        logic addr_hit;
    } match_t;

    typedef logic [2:0] fwd_sel_t; // 0 is the register file, k+1 is stage k.

    typedef enum logic [1:0] {
        CAUSE_NONE       = 2'd0,
        CAUSE_LOAD_USE   = 2'd1,
        CAUSE_STORE_LOAD = 2'd2
    } cause_t;

    typedef struct packed {
        fwd_sel_t fwd1;
        fwd_sel_t fwd2;
        logic     bubble;
        cause_t   cause;
    } issue_rec_t;

endpackage

`default_nettype wire

// File: hw/issue_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module issue_ctrl #(
    parameter int NUM_STAGES = 3
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_req,
    input  hazard_pkg::inst_word_u in_inst,
    input  logic                   need_bubble,
    input  hazard_pkg::cause_t     cause,
    input  hazard_pkg::fwd_sel_t   fwd1,
    input  hazard_pkg::fwd_sel_t   fwd2,
    output logic                   in_ack,
    output hazard_pkg::cand_t      cand,
    output logic                   slot_step,
    output hazard_pkg::slot_t      slot_in,
    output hazard_pkg::issue_rec_t out_rec
);

    logic               seen;
    logic               bubbled;
    hazard_pkg::cause_t bubble_cause;

    assign seen      = in_req && !in_ack; // new request not yet acknowledged.
    assign slot_step = seen;              // every seen cycle is a bubble or an issue.

    always_comb begin
        cand     = '0;
        cand.rs1 = in_inst.i.rs1;
        cand.rs2 = in_inst.s.rs2;
        cand.rd  = in_inst.i.rd;
        case (in_inst.i.opcode)
            hazard_pkg::OPC_OP: begin
                cand.uses_rs1  = 1'b1;
                cand.uses_rs2  = 1'b1;
                cand.writes_rd = 1'b1;
            end
            hazard_pkg::OPC_OP_IMM: begin
                cand.uses_rs1  = 1'b1;
                cand.writes_rd = 1'b1;
            end
            hazard_pkg::OPC_LOAD: begin
                cand.uses_rs1  = 1'b1;
                cand.writes_rd = 1'b1;
                cand.is_load   = 1'b1;
                cand.offset    = in_inst.i.imm;
            end
            hazard_pkg::OPC_STORE: begin
                cand.uses_rs1 = 1'b1;
                cand.uses_rs2 = 1'b1;
                cand.is_store = 1'b1;
                cand.offset   = {in_inst.s.imm_hi, in_inst.s.imm_lo};
            end
            default: begin
            end
        endcase
        if (cand.rd == 5'd0) begin
            cand.writes_rd = 1'b0; // x0 never produces a value.
        end
    end

    // a bubble enters stage 0 as an empty slot.
    always_comb begin
        slot_in = '0;
        if (!need_bubble) begin
            slot_in.valid     = 1'b1;
            slot_in.writes_rd = cand.writes_rd;
            slot_in.rd        = cand.rd;
            slot_in.is_load   = cand.is_load;
            slot_in.is_store  = cand.is_store;
            slot_in.base      = cand.rs1;
            slot_in.offset    = cand.offset;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_ack       <= 1'b0;
            bubbled      <= 1'b0;
            bubble_cause <= hazard_pkg::CAUSE_NONE;
            out_rec      <= '0;
        end else if (seen) begin
            if (need_bubble) begin
                bubbled      <= 1'b1;
                bubble_cause <= cause;
            end else begin
                in_ack         <= 1'b1;
                bubbled        <= 1'b0;
                out_rec.fwd1   <= fwd1;
                out_rec.fwd2   <= fwd2;
                out_rec.bubble <= bubbled;
                out_rec.cause  <= bubbled ? bubble_cause : hazard_pkg::CAUSE_NONE;
            end
        end else if (in_ack && !in_req) begin
            in_ack <= 1'b0; // return to zero.
        end
    end

    a_ack_needs_req: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(in_ack) |-> $past(in_req)
    ) else $error("in_ack rose without a pending in_req");

endmodule

`default_nettype wire

// File: hw/stage_slot.sv
`timescale 1ns/1ns
`default_nettype none

module stage_slot (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               slot_step,
    input  hazard_pkg::slot_t  prev,
    input  hazard_pkg::cand_t  cand,
    output hazard_pkg::slot_t  cur,
    output hazard_pkg::match_t hit
);

    logic rd_live;
    logic same_addr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cur <= '0;
        end else if (slot_step) begin
            cur <= prev; // elastic shift, idle cycles hold.
        end
    end

    assign rd_live   = cur.valid && cur.writes_rd && (cur.rd != 5'd0);
    assign same_addr = (cur.base == cand.rs1) && (cur.offset == cand.offset);

    always_comb begin
        hit.rs1_hit  = rd_live && cand.uses_rs1 && (cur.rd == cand.rs1);
        hit.rs2_hit  = rd_live && cand.uses_rs2 && (cur.rd == cand.rs2);
        hit.addr_hit = cur.valid && cur.is_store && same_addr;
    end

    // decode drops writes_rd for x0 before the slot is built.
    a_no_x0_dest: assert property (
        @(posedge clk) disable iff (!rst_n)
        (cur.valid && cur.writes_rd) |-> (cur.rd != 5'd0)
    ) else $error("slot holds a live write to x0");

endmodule

`default_nettype wire

// File: hw/hazard_resolver.sv
`timescale 1ns/1ns
`default_nettype none

module hazard_resolver #(
    parameter int NUM_STAGES = 3
) (
    input  hazard_pkg::match_t [NUM_STAGES-1:0] hits,
    input  hazard_pkg::slot_t  [NUM_STAGES-1:0] stages,
    input  hazard_pkg::cand_t                   cand,
    output logic                                need_bubble,
    output hazard_pkg::cause_t                  cause,
    output hazard_pkg::fwd_sel_t                fwd1,
    output hazard_pkg::fwd_sel_t                fwd2
);

    logic load_use;
    logic store_load;
    logic ex_load;

    assign ex_load = stages[0].valid && stages[0].is_load;

    // a load in EX has no data yet for a dependent instruction.
    assign load_use = ex_load && (hits[0].rs1_hit || hits[0].rs2_hit);

    // load right behind a store to the same base and offset.
    assign store_load = cand.is_load && hits[0].addr_hit;

    assign need_bubble = load_use || store_load;

    always_comb begin
        if (load_use) begin
            cause = hazard_pkg::CAUSE_LOAD_USE; // load-use wins.
        end else if (store_load) begin
            cause = hazard_pkg::CAUSE_STORE_LOAD;
        end else begin
            cause = hazard_pkg::CAUSE_NONE;
        end
    end

    // Search from the oldest stage towards EX so the nearest producer
    // overwrites any older match.
    always_comb begin
        fwd1 = '0;
        fwd2 = '0;
        for (int k = NUM_STAGES - 1; k >= 0; k--) begin
            if (hits[k].rs1_hit) begin
                fwd1 = hazard_pkg::fwd_sel_t'(k + 1);
            end
            if (hits[k].rs2_hit) begin
                fwd2 = hazard_pkg::fwd_sel_t'(k + 1);
            end
        end
    end

    // stage 0 is empty right after a bubble, so a second one cannot follow.
    always_comb begin
        if (need_bubble) begin
            a_bubble_needs_ex: assert (stages[0].valid)
                else $error("bubble requested with an empty EX stage");
        end
    end

endmodule

`default_nettype wire

// File: hw/hazard_unit_top.sv
`timescale 1ns/1ns
`default_nettype none

module hazard_unit_top #(
    parameter int NUM_STAGES = 3 // 2 to 7, limited by the 3-bit forward code.
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_req,
    input  hazard_pkg::inst_word_u in_inst,
    output logic                   in_ack,
    output hazard_pkg::issue_rec_t out_rec
);

    hazard_pkg::cand_t                   cand;
    logic                                slot_step;
    hazard_pkg::slot_t                   slot_in;
    hazard_pkg::slot_t  [NUM_STAGES:0]   chain; // chain[0] is the entry, chain[k+1] stage k.
    hazard_pkg::match_t [NUM_STAGES-1:0] hits;
    logic                                need_bubble;
    hazard_pkg::cause_t                  cause;
    hazard_pkg::fwd_sel_t                fwd1;
    hazard_pkg::fwd_sel_t                fwd2;

    assign chain[0] = slot_in;

    issue_ctrl #(
        .NUM_STAGES (NUM_STAGES)
    ) u_issue (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_req      (in_req),
        .in_inst     (in_inst),
        .need_bubble (need_bubble),
        .cause       (cause),
        .fwd1        (fwd1),
        .fwd2        (fwd2),
        .in_ack      (in_ack),
        .cand        (cand),
        .slot_step   (slot_step),
        .slot_in     (slot_in),
        .out_rec     (out_rec)
    );

    for (genvar k = 0; k < NUM_STAGES; k++) begin : g_stage
        stage_slot u_slot (
            .clk       (clk),
            .rst_n     (rst_n),
            .slot_step (slot_step),
            .prev      (chain[k]),
            .cand      (cand),
            .cur       (chain[k+1]),
            .hit       (hits[k])
        );
    end

    hazard_resolver #(
        .NUM_STAGES (NUM_STAGES)
    ) u_resolver (
        .hits        (hits),
        .stages      (chain[NUM_STAGES:1]),
        .cand        (cand),
        .need_bubble (need_bubble),
        .cause       (cause),
        .fwd1        (fwd1),
        .fwd2        (fwd2)
    );

endmodule

`default_nettype wire

// File: sim/tb_clkgen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clkgen #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1; // released just after an edge.
    end

endmodule

`default_nettype wire

// File: sim/tb_hazard.sv
`timescale 1ns/1ns
`default_nettype none

module tb_hazard;

    localparam int NUM_STAGES = 3;
    localparam int TIMEOUT    = 20;
    localparam int NUM_RANDOM = 200;

    localparam logic [6:0] ADDI = hazard_pkg::OPC_OP_IMM;
    localparam logic [6:0] LOAD = hazard_pkg::OPC_LOAD;

    localparam hazard_pkg::cause_t NONE = hazard_pkg::CAUSE_NONE;
    localparam hazard_pkg::cause_t LU   = hazard_pkg::CAUSE_LOAD_USE;
    localparam hazard_pkg::cause_t SL   = hazard_pkg::CAUSE_STORE_LOAD;

    logic                   clk;
    logic                   rst_n;
    logic                   in_req;
    hazard_pkg::inst_word_u in_inst;
    logic                   in_ack;
    hazard_pkg::issue_rec_t out_rec;

    string                  row_name[$];
    logic [31:0]            row_word[$];
    int                     row_gap[$]; // idle cycles before the request.
    hazard_pkg::issue_rec_t row_exp[$];

    hazard_pkg::slot_t m_chain[NUM_STAGES]; // model of the stage chain with EX at index 0.
    logic [31:0]       lfsr_state;

    tb_clkgen #(
        .PERIOD       (8),
        .RESET_CYCLES (5)
    ) clkgen_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    hazard_unit_top #(
        .NUM_STAGES (NUM_STAGES)
    ) dut_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .in_req  (in_req),
        .in_inst (in_inst),
        .in_ack  (in_ack),
        .out_rec (out_rec)
    );

    function automatic logic [31:0] enc_r(input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
        return {7'd0, rs2, rs1, 3'd0, rd, hazard_pkg::OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [6:0] opc, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, 3'd0, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [4:0] rs2, input logic [4:0] rs1,
                                          input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'd2, imm[4:0], hazard_pkg::OPC_STORE};
    endfunction

    function automatic hazard_pkg::issue_rec_t make_rec(input int f1, input int f2,
                                                        input logic b, input hazard_pkg::cause_t c);
        hazard_pkg::issue_rec_t r;
        r.fwd1   = hazard_pkg::fwd_sel_t'(f1);
        r.fwd2   = hazard_pkg::fwd_sel_t'(f2);
        r.bubble = b;
        r.cause  = c;
        return r;
    endfunction

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val        = {val[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH %s expected %0h actual %0h", name, expected, actual);
            $display("Some tests failed");
            $fatal(1, "simulation stopped");
        end
    endtask

    function automatic logic produces(input hazard_pkg::slot_t s, input logic used,
                                      input logic [4:0] src);
        return s.valid && s.writes_rd && used && (s.rd == src);
    endfunction

    task automatic shift_in(input hazard_pkg::slot_t s);
        for (int k = NUM_STAGES - 1; k > 0; k--) begin
            m_chain[k] = m_chain[k-1];
        end
        m_chain[0] = s;
    endtask

    // the model issues one instruction after an optional bubble.
    task automatic model_issue(input logic [31:0] w, output hazard_pkg::issue_rec_t r);
        logic [6:0]        opc;
        logic [4:0]        rs1;
        logic [4:0]        rs2;
        logic              u1;
        logic              u2;
        hazard_pkg::slot_t ex;
        hazard_pkg::slot_t nw;
        opc = w[6:0];
        rs1 = w[19:15];
        rs2 = w[24:20];
        nw  = '0;
        u1  = 1'b0;
        u2  = 1'b0;
        nw.valid = 1'b1;
        nw.rd    = w[11:7];
        nw.base  = rs1;
        case (opc)
            hazard_pkg::OPC_OP:     {u1, u2, nw.writes_rd} = 3'b111;
            hazard_pkg::OPC_OP_IMM: {u1, u2, nw.writes_rd} = 3'b101;
            hazard_pkg::OPC_LOAD:   {u1, u2, nw.writes_rd, nw.is_load} = 4'b1011;
            hazard_pkg::OPC_STORE:  {u1, u2, nw.writes_rd, nw.is_store} = 4'b1101;
            default:                u1 = 1'b0;
        endcase
        if (nw.is_load) begin
            nw.offset = w[31:20];
        end else if (nw.is_store) begin
            nw.offset = {w[31:25], w[11:7]};
        end
        if (nw.rd == 5'd0) begin
            nw.writes_rd = 1'b0;
        end
        r  = '0;
        ex = m_chain[0];
        if (ex.is_load && (produces(ex, u1, rs1) || produces(ex, u2, rs2))) begin
            r.bubble = 1'b1;
            r.cause  = LU;
        end else if (nw.is_load && ex.valid && ex.is_store && (ex.base == rs1) &&
                     (ex.offset == nw.offset)) begin
            r.bubble = 1'b1;
            r.cause  = SL;
        end
        if (r.bubble) begin
            shift_in('0);
        end
        for (int k = 0; k < NUM_STAGES; k++) begin
            if (r.fwd1 == 3'd0 && produces(m_chain[k], u1, rs1)) begin
                r.fwd1 = hazard_pkg::fwd_sel_t'(k + 1);
            end
            if (r.fwd2 == 3'd0 && produces(m_chain[k], u2, rs2)) begin
                r.fwd2 = hazard_pkg::fwd_sel_t'(k + 1);
            end
        end
        shift_in(nw);
    endtask

    // full four-phase transfer; starts and ends 1 ns after a rising edge.
    task automatic send(input logic [31:0] w, input int gap,
                        output hazard_pkg::issue_rec_t r, output int latency);
        int cycles;
        for (int i = 0; i < gap; i++) begin
            @(posedge clk);
            #1;
            check("idle_ack", 32'd0, 32'(in_ack));
        end
        in_inst = w;
        in_req  = 1'b1;
        latency = 0;
        while (!in_ack) begin
            @(posedge clk);
            #1;
            latency++;
            if (latency > TIMEOUT) begin
                fail_run("in_ack did not rise within the timeout after in_req");
            end
        end
        r = out_rec;
        @(posedge clk);
        #1;
        check("ack_hold", 32'd1, 32'(in_ack)); // ack holds while req is high.
        in_req = 1'b0;
        cycles = 0;
        while (in_ack) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > TIMEOUT) begin
                fail_run("in_ack did not fall within the timeout after in_req dropped");
            end
        end
        check("ack_fall", 32'd1, cycles);
    endtask

    task automatic add_row(input string name, input logic [31:0] w, input int gap,
                           input hazard_pkg::issue_rec_t exp);
        row_name.push_back(name);
        row_word.push_back(w);
        row_gap.push_back(gap);
        row_exp.push_back(exp);
    endtask

    task automatic build_table();
        add_row("indep", enc_i(ADDI, 5'd1, 5'd0, 12'd5), 0, make_rec(0, 0, 1'b0, NONE));
        add_row("fwd_ex", enc_r(5'd2, 5'd1, 5'd0), 0, make_rec(1, 0, 1'b0, NONE));
        add_row("fwd_mem", enc_r(5'd3, 5'd1, 5'd0), 0, make_rec(2, 0, 1'b0, NONE));
        add_row("fwd_wb", enc_r(5'd4, 5'd1, 5'd0), 15, make_rec(3, 0, 1'b0, NONE));
        add_row("fwd_none", enc_r(5'd5, 5'd1, 5'd0), 0, make_rec(0, 0, 1'b0, NONE));
        add_row("prod_old", enc_i(ADDI, 5'd6, 5'd0, 12'd1), 0, make_rec(0, 0, 1'b0, NONE));
        add_row("prod_new", enc_i(ADDI, 5'd6, 5'd0, 12'd2), 3, make_rec(0, 0, 1'b0, NONE));
        add_row("nearest", enc_r(5'd7, 5'd5, 5'd6), 0, make_rec(3, 1, 1'b0, NONE));
        add_row("write_x0", enc_i(ADDI, 5'd0, 5'd0, 12'd9), 0, make_rec(0, 0, 1'b0, NONE));
        add_row("read_x0", enc_r(5'd8, 5'd0, 5'd7), 0, make_rec(0, 2, 1'b0, NONE));
        add_row("load_a", enc_i(LOAD, 5'd9, 5'd8, 12'd0), 0, make_rec(1, 0, 1'b0, NONE));
        add_row("load_use_rs1", enc_r(5'd10, 5'd9, 5'd0), 0, make_rec(2, 0, 1'b1, LU));
        add_row("load_b", enc_i(LOAD, 5'd11, 5'd2, 12'd4), 0, make_rec(0, 0, 1'b0, NONE));
        add_row("load_use_rs2", enc_r(5'd12, 5'd0, 5'd11), 7, make_rec(0, 2, 1'b1, LU));
        add_row("store_a", enc_s(5'd12, 5'd3, 12'd8), 0, make_rec(0, 1, 1'b0, NONE));
        add_row("store_load", enc_i(LOAD, 5'd13, 5'd3, 12'd8), 10, make_rec(0, 0, 1'b1, SL));
        add_row("store_b", enc_s(5'd1, 5'd3, 12'd16), 0, make_rec(0, 0, 1'b0, NONE));
        add_row("load_diff", enc_i(LOAD, 5'd14, 5'd3, 12'd20), 0, make_rec(0, 0, 1'b0, NONE));
        // its rs1 field would hit the load in EX if the upper immediate class were decoded.
        add_row("other_op", {12'd0, 5'd14, 3'd0, 5'd15, 7'b0110111}, 0,
                make_rec(0, 0, 1'b0, NONE));
        add_row("after_other", enc_r(5'd16, 5'd15, 5'd14), 0, make_rec(0, 2, 1'b0, NONE));
    endtask

    initial begin : main
        hazard_pkg::issue_rec_t got;
        hazard_pkg::issue_rec_t exp;
        logic [31:0]            word;
        logic [31:0]            cls;
        logic [31:0]            rd;
        logic [31:0]            ra;
        logic [31:0]            rb;
        logic [31:0]            imm;
        logic [31:0]            gap;
        int                     lat;
        int                     cycles;
        in_req     = 1'b0;
        in_inst    = '0;
        lfsr_state = 32'h3f0f4e35;
        for (int k = 0; k < NUM_STAGES; k++) begin
            m_chain[k] = '0;
        end
        build_table();
        cycles = 0;
        while (rst_n !== 1'b1) begin
            @(posedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                fail_run("reset was not released within the timeout");
            end
        end
        @(posedge clk);
        #1;
        check("reset_ack", 32'd0, 32'(in_ack));
        check("reset_rec", 32'd0, 32'(out_rec));
        for (int n = 0; n < row_word.size(); n++) begin
            send(row_word[n], row_gap[n], got, lat);
            model_issue(row_word[n], exp);
            check(row_name[n], 32'(row_exp[n]), 32'(got));
            check({row_name[n], "_model"}, 32'(row_exp[n]), 32'(exp));
            check({row_name[n], "_latency"}, row_exp[n].bubble ? 32'd2 : 32'd1, lat);
        end
        for (int n = 0; n < NUM_RANDOM; n++) begin
            take_bits(2, cls);
            take_bits(3, rd); // x0 to x7 keeps hazards frequent.
            take_bits(3, ra);
            take_bits(3, rb);
            take_bits(4, imm);
            take_bits(2, gap);
            case (cls[1:0])
                2'd0:    word = enc_r(rd[4:0], ra[4:0], rb[4:0]);
                2'd1:    word = enc_i(ADDI, rd[4:0], ra[4:0], {8'd0, imm[3:0]});
                2'd2:    word = enc_i(LOAD, rd[4:0], ra[4:0], {8'd0, imm[1:0], 2'd0});
                default: word = enc_s(rb[4:0], ra[4:0], {8'd0, imm[1:0], 2'd0});
            endcase
            send(word, int'(gap), got, lat);
            model_issue(word, exp);
            check($sformatf("random_%0d", n), 32'(exp), 32'(got));
            check($sformatf("random_%0d_latency", n), exp.bubble ? 32'd2 : 32'd1, lat);
        end
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
hw/hazard_pkg.sv
hw/issue_ctrl.sv
hw/stage_slot.sv
hw/hazard_resolver.sv
hw/hazard_unit_top.sv
sim/tb_clkgen.sv
sim/tb_hazard.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_hazard -f tb.f -o tb_hazard_sim

./obj_dir/tb_hazard_sim 2>&1 | tee sim.log

if grep -q "Some tests failed" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
if ! grep -q "All tests passed" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"
